// File: all.f
len5_pkg.sv
memory_pkg.sv
fetch_if.sv
pc_gen.sv
fetch_buffer.sv
issue_stage.sv
frontend.sv
tb_frontend.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench

LOG = sim.log

# Build, run, then fail on a crashed run or a reported failure in the log
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_frontend -f all.f
	./obj_dir/Vtb_frontend > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// File: tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;

  import len5_pkg::*;
  import memory_pkg::*;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 flush_i;
  logic [XLEN-1:0]      addr_o;
  logic                 addr_valid_o;
  logic                 addr_ready_i;
  logic                 data_ready_o;
  icache_frontend_ans_t icache_frontend_ans_i;
  logic                 issue_ready_i;
  logic                 issue_valid_o;
  logic [ILEN-1:0]      instruction_o;
  logic [XLEN-1:0]      curr_pc_o;
  prediction_t          pred_o;
  resolution_t          res_i;
  logic                 except_o;
  except_code_t         except_code_o;
  logic                 except_i;
  logic [XLEN-1:0]      except_pc_i;

  // Random source and cycle count
  logic [15:0]     lfsr_q;
  int unsigned     cyc;
  // Cache model requests in order with the cycle each answer is due
  logic [XLEN-1:0] req_addr[$];
  int unsigned     req_due[$];
  // Reference model pc of the next entry decode should receive
  logic [XLEN-1:0] exp_pc;
  int unsigned     issued;
  int unsigned     checks;
  int unsigned     errors;
  // Kinds of entries decode received with the expected outcome
  int unsigned     n_jal;
  int unsigned     n_bwd;
  int unsigned     n_fwd;
  int unsigned     n_misal;
  int unsigned     n_fault;
  // 0 decode always ready, 1 random, 2 stalled
  int unsigned     ready_mode;
  // Pending redirect with flush for the next edge
  logic            fire_q;
  logic            fire_mis;
  logic [XLEN-1:0] fire_pc;
  int unsigned     test_err0;
  int unsigned     test_iss0;

  frontend i_frontend (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // RISC-V encodings with x0 in every register field
  function automatic logic [31:0] enc_jal(input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_beq(input logic [31:0] off);
    return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  // Memory content is a function of the word index within 64 bytes
  function automatic logic [31:0] instr_at(input logic [31:0] a);
    case (a[5:2])
      4'd3:    return enc_jal(-32'd16);
      4'd7:    return enc_beq(-32'd8);
      4'd11:   return enc_beq(32'd12);
      4'd13:   return enc_jal(32'd6);
      default: return 32'h0000_0013;
    endcase
  endfunction

  function automatic logic fault_at(input logic [31:0] a);
    return (a >= 32'h0000_0800) && (a <= 32'h0000_08FF);
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
  endtask

  // Compare the entry taken by decode with the model, then advance the model
  task automatic check_issue();
    logic [31:0]  pc;
    logic         exp_exc;
    except_code_t exp_code;
    logic         exp_taken;
    logic [31:0]  exp_tgt;
    pc        = exp_pc;
    exp_exc   = 1'b0;
    exp_code  = INSTR_MISALIGNED;
    exp_taken = 1'b0;
    exp_tgt   = pc + 32'd4;
    if (fault_at(pc)) begin
      // Faulted words are never predicted
      exp_exc  = 1'b1;
      exp_code = INSTR_ACCESS_FAULT;
      if (except_o && except_code_o == INSTR_ACCESS_FAULT) begin
        n_fault++;
      end
    end else begin
      case (pc[5:2])
        4'd3: begin
          exp_taken = 1'b1;
          exp_tgt   = pc - 32'd16;
          if (pred_o.taken && pred_o.target == exp_tgt) begin
            n_jal++;
          end
        end
        4'd7: begin
          exp_taken = 1'b1;
          exp_tgt   = pc - 32'd8;
          if (pred_o.taken && pred_o.target == exp_tgt) begin
            n_bwd++;
          end
        end
        4'd11: begin
          if (curr_pc_o == pc && !pred_o.taken) begin
            n_fwd++;
          end
        end
        4'd13: begin
          // Target pc+6 is not word aligned
          exp_exc = 1'b1;
          if (except_o && except_code_o == INSTR_MISALIGNED) begin
            n_misal++;
          end
        end
        default: ;
      endcase
    end
    checks++;
    if (curr_pc_o != pc) begin
      report_mismatch("curr_pc_o", curr_pc_o, pc);
    end
    if (instruction_o != instr_at(pc)) begin
      report_mismatch("instruction_o", instruction_o, instr_at(pc));
    end
    if (pred_o.taken != exp_taken) begin
      report_mismatch("pred_o.taken", 32'(pred_o.taken), 32'(exp_taken));
    end
    // Not taken entries carry the fall-through address
    if (pred_o.target != exp_tgt) begin
      report_mismatch("pred_o.target", pred_o.target, exp_tgt);
    end
    if (except_o != exp_exc) begin
      report_mismatch("except_o", 32'(except_o), 32'(exp_exc));
    end
    if (exp_exc && except_code_o != exp_code) begin
      report_mismatch("except_code_o", 32'(except_code_o), 32'(exp_code));
    end
    exp_pc = exp_taken ? exp_tgt : pc + 32'd4;
    issued++;
  endtask

  // One clock cycle of decode checks, cache model and input drive
  task automatic step();
    icache_frontend_ans_t ans;
    resolution_t          res;
    int unsigned          lat;
    @(posedge clk_i);
    cyc++;
    if (issue_valid_o && issue_ready_i) begin
      check_issue();
    end
    // Oldest request answers once its latency is over
    ans = '0;
    if (req_addr.size() != 0 && req_due[0] <= cyc) begin
      ans.valid = 1'b1;
      ans.vaddr = req_addr[0];
      ans.line  = instr_at(req_addr[0]);
      ans.fault = fault_at(req_addr[0]);
      void'(req_addr.pop_front());
      void'(req_due.pop_front());
    end
    icache_frontend_ans_i <= ans;
    if (addr_valid_o && addr_ready_i) begin
      lat = rand_bits(2);
      req_addr.push_back(addr_o);
      req_due.push_back(cyc + lat);
    end
    // Cache ready about three cycles in four
    addr_ready_i <= (rand_bits(2) != 0);
    if (ready_mode == 1) begin
      issue_ready_i <= (rand_bits(1) != 0);
    end else begin
      issue_ready_i <= (ready_mode == 0);
    end
    res = '0;
    except_i <= 1'b0;
    flush_i  <= 1'b0;
    if (fire_q) begin
      // Decode stalls so nothing leaves the slot while it is flushed
      flush_i       <= 1'b1;
      issue_ready_i <= 1'b0;
      if (fire_mis) begin
        res.valid      = 1'b1;
        res.mispredict = 1'b1;
        res.target     = fire_pc;
      end else begin
        except_i    <= 1'b1;
        except_pc_i <= fire_pc;
      end
      exp_pc = fire_pc;
      fire_q = 1'b0;
    end
    res_i <= res;
  endtask

  task automatic redirect_to(input logic mis, input logic [31:0] pc);
    fire_q   = 1'b1;
    fire_mis = mis;
    fire_pc  = pc;
    step();
  endtask

  task automatic run_issue(input int unsigned n, input int unsigned limit);
    int unsigned goal;
    int unsigned waited;
    goal   = issued + n;
    waited = 0;
    while (issued < goal && waited < limit) begin
      step();
      waited++;
    end
    if (issued < goal) begin
      report_failure($sformatf("timeout, only %0d of %0d instructions issued",
                               n - (goal - issued), n));
    end
  endtask

  // Decode stalled until the buffer is full, then fetch must have stopped
  task automatic wait_full(input int unsigned limit);
    int unsigned waited;
    waited = 0;
    do begin
      step();
      waited++;
    end while (data_ready_o && waited < limit);
    checks++;
    if (data_ready_o) begin
      report_failure("fetch buffer never filled while decode was stalled");
    end else if (addr_valid_o) begin
      report_mismatch("addr_valid_o with a full buffer", 32'd1, 32'd0);
    end
  endtask

  task automatic test_start();
    test_err0 = errors;
    test_iss0 = issued;
  endtask

  task automatic test_done(input int unsigned num, input string name);
    $display("Test %0d %s: %0d issued, %0d errors", num, name,
             issued - test_iss0, errors - test_err0);
  endtask

  initial begin
    logic [XLEN-1:0] tgt;
    rst_n_i               = 1'b0;
    flush_i               = 1'b0;
    addr_ready_i          = 1'b0;
    icache_frontend_ans_i = '0;
    issue_ready_i         = 1'b0;
    res_i                 = '0;
    except_i              = 1'b0;
    except_pc_i           = '0;
    lfsr_q     = 16'd46;
    cyc        = 0;
    exp_pc     = BOOT_PC;
    issued     = 0;
    checks     = 0;
    errors     = 0;
    n_jal      = 0;
    n_bwd      = 0;
    n_fwd      = 0;
    n_misal    = 0;
    n_fault    = 0;
    ready_mode = 0;
    fire_q     = 1'b0;
    fire_mis   = 1'b0;
    fire_pc    = '0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Boot, then the sequential stream with its JAL loop
    test_start();
    step();
    checks++;
    if (addr_valid_o || issue_valid_o || except_o) begin
      report_failure("front end not idle in the first cycle after reset");
    end
    step();
    checks++;
    if (!addr_valid_o) begin
      report_failure("no fetch request one cycle after reset");
    end else if (addr_o != BOOT_PC) begin
      report_mismatch("addr_o", addr_o, BOOT_PC);
    end
    run_issue(16, 400);
    if (n_jal == 0) begin
      report_failure("no taken JAL was issued");
    end
    test_done(1, "boot and sequential fetch");

    // Backward branch loop, then a forward branch
    test_start();
    redirect_to(1'b1, 32'h0000_0110);
    run_issue(8, 400);
    redirect_to(1'b1, 32'h0000_0120);
    run_issue(5, 400);
    if (n_bwd == 0 || n_fwd == 0) begin
      report_failure("a backward or forward BEQ was not issued");
    end
    test_done(2, "static prediction");

    test_start();
    redirect_to(1'b0, 32'h0000_0130);
    run_issue(4, 400);
    redirect_to(1'b0, 32'h0000_0800);
    run_issue(8, 400);
    if (n_misal == 0) begin
      report_failure("no misaligned JAL was issued");
    end
    if (n_fault == 0) begin
      report_failure("no access fault was issued");
    end
    test_done(3, "exceptions");

    test_start();
    for (int unsigned k = 0; k < 5; k++) begin
      tgt = rand_bits(8) << 2;
      redirect_to(1'b1, tgt);
      run_issue(6, 400);
    end
    test_done(4, "mispredict recovery");

    // Random stalls and latency with a flush while the buffer is full
    test_start();
    for (int unsigned k = 0; k < 3; k++) begin
      ready_mode = 1;
      run_issue(100, 4000);
      ready_mode = 2;
      wait_full(100);
      tgt = rand_bits(8) << 2;
      redirect_to(1'b0, tgt);
    end
    ready_mode = 1;
    run_issue(20, 1000);
    test_done(5, "back-pressure and flush");

    $display("Summary: %0d instructions issued, %0d checks, %0d errors",
             issued, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: frontend.sv
`timescale 1ns/1ps

module frontend (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             flush_i,

  // Instruction cache side
  output logic [len5_pkg::XLEN-1:0]        addr_o,
  output logic                             addr_valid_o,
  input  logic                             addr_ready_i,
  output logic                             data_ready_o,
  input  memory_pkg::icache_frontend_ans_t icache_frontend_ans_i,

  // Decode side
  input  logic                             issue_ready_i,
  output logic                             issue_valid_o,
  output logic [len5_pkg::ILEN-1:0]        instruction_o,
  output logic [len5_pkg::XLEN-1:0]        curr_pc_o,
  output len5_pkg::prediction_t            pred_o,

  // Branch unit
  input  len5_pkg::resolution_t            res_i,

  // Exceptions toward and from the back end
  output logic                             except_o,
  output len5_pkg::except_code_t           except_code_o,
  input  logic                             except_i,
  input  logic [len5_pkg::XLEN-1:0]        except_pc_i
);

  import len5_pkg::*;
  import memory_pkg::*;

  logic                  pred_redirect;
  logic [XLEN-1:0]       pred_target;
  // Winner of the pc_gen priority mux, also realigns the buffer
  logic                  redirect;
  logic [XLEN-1:0]       redirect_pc;
  logic [FBUF_CNT_W-1:0] free_slots;

  fetch_if u_fetch_if ();

  pc_gen u_pc_gen (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .except_i       (except_i),
    .except_pc_i    (except_pc_i),
    .res_i          (res_i),
    .pred_redirect_i(pred_redirect),
    .pred_target_i  (pred_target),
    .ans_valid_i    (icache_frontend_ans_i.valid),
    .free_slots_i   (free_slots),
    .addr_ready_i   (addr_ready_i),
    .addr_o         (addr_o),
    .addr_valid_o   (addr_valid_o),
    .redirect_o     (redirect),
    .redirect_pc_o  (redirect_pc)
  );

  fetch_buffer u_fetch_buffer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .redirect_i   (redirect),
    .redirect_pc_i(redirect_pc),
    .icache_ans_i (icache_frontend_ans_i),
    .data_ready_o (data_ready_o),
    .free_slots_o (free_slots),
    .fetch_src    (u_fetch_if.src)
  );

  issue_stage u_issue_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .fetch_dst      (u_fetch_if.dst),
    .issue_ready_i  (issue_ready_i),
    .issue_valid_o  (issue_valid_o),
    .instruction_o  (instruction_o),
    .curr_pc_o      (curr_pc_o),
    .pred_o         (pred_o),
    .except_o       (except_o),
    .except_code_o  (except_code_o),
    .pred_redirect_o(pred_redirect),
    .pred_target_o  (pred_target)
  );

endmodule

// File: issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        flush_i,
  fetch_if.dst                        fetch_dst,
  input  logic                        issue_ready_i,
  output logic                        issue_valid_o,
  output logic [len5_pkg::ILEN-1:0]   instruction_o,
  output logic [len5_pkg::XLEN-1:0]   curr_pc_o,
  output len5_pkg::prediction_t       pred_o,
  output logic                        except_o,
  output len5_pkg::except_code_t      except_code_o,
  output logic                        pred_redirect_o,
  output logic [len5_pkg::XLEN-1:0]   pred_target_o
);

  import len5_pkg::*;

  logic            take;
  logic            is_jal;
  logic            is_branch;
  logic [XLEN-1:0] j_imm;
  logic [XLEN-1:0] b_imm;
  logic [XLEN-1:0] target;
  logic            taken;
  logic            misaligned;
  logic            jump_ok;

  // Output slot
  logic            valid_q;
  instr_u          instr_q;
  logic [XLEN-1:0] pc_q;
  prediction_t     pred_q;
  logic            except_q;
  except_code_t    code_q;

  // Slot accepts when empty or when decode drains it this cycle
  assign fetch_dst.ready = ~valid_q | issue_ready_i;
  assign take            = fetch_dst.valid & fetch_dst.ready;

  // Predecode
  assign is_jal    = (fetch_dst.instr.bj.opcode == OPC_JAL);
  assign is_branch = (fetch_dst.instr.bj.opcode == OPC_BRANCH);

  // J immediate, imm[20|10:1|11|19:12]
  assign j_imm = {{(XLEN-20){fetch_dst.instr.bj.imm_hi[6]}},
                  fetch_dst.instr.bj.rs1, fetch_dst.instr.bj.funct3,
                  fetch_dst.instr.bj.rs2[0], fetch_dst.instr.bj.imm_hi[5:0],
                  fetch_dst.instr.bj.rs2[4:1], 1'b0};

  // B immediate, imm[12|10:5] and imm[4:1|11]
  assign b_imm = {{(XLEN-12){fetch_dst.instr.bj.imm_hi[6]}},
                  fetch_dst.instr.bj.rd_imm[0], fetch_dst.instr.bj.imm_hi[5:0],
                  fetch_dst.instr.bj.rd_imm[4:1], 1'b0};

  assign target = fetch_dst.pc + (is_jal ? j_imm : b_imm);

  // Static rule: JAL always, branches only backward
  // A faulted word carries no usable opcode
  assign taken      = ~fetch_dst.fault & (is_jal | (is_branch & b_imm[XLEN-1]));
  assign misaligned = taken & (target[1:0] != 2'b00);
  assign jump_ok    = taken & ~misaligned;

  // One pulse per accepted jump
  assign pred_redirect_o = take & jump_ok & ~flush_i;
  assign pred_target_o   = target;

  // Payload loads on every accepted entry
  always_ff @(posedge clk_i) begin
    if (take) begin
      instr_q      <= fetch_dst.instr;
      pc_q         <= fetch_dst.pc;
      pred_q.taken <= jump_ok;
      // Fall-through address when not taken
      pred_q.target <= jump_ok ? target : fetch_dst.pc + XLEN'(4);
      except_q     <= fetch_dst.fault | misaligned;
      code_q       <= fetch_dst.fault ? INSTR_ACCESS_FAULT : INSTR_MISALIGNED;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (issue_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  assign issue_valid_o = valid_q;
  assign instruction_o = instr_q.raw;
  assign curr_pc_o     = pc_q;
  assign pred_o        = pred_q;
  assign except_o      = valid_q & except_q;
  assign except_code_o = code_q;

  // Decode sees a stable entry while it stalls
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (issue_valid_o && !issue_ready_i && !flush_i) |=>
      (issue_valid_o && $stable(curr_pc_o) && $stable(instruction_o)
       && $stable(pred_o) && $stable(except_o)));

endmodule

// File: fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              flush_i,
  input  logic                              redirect_i,
  input  logic [len5_pkg::XLEN-1:0]         redirect_pc_i,
  input  memory_pkg::icache_frontend_ans_t  icache_ans_i,
  output logic                              data_ready_o,
  output logic [memory_pkg::FBUF_CNT_W-1:0] free_slots_o,
  fetch_if.src                              fetch_src
);

  import len5_pkg::*;
  import memory_pkg::*;

  // Entry storage
  logic [XLEN-1:0] pc_mem    [FBUF_DEPTH];
  instr_u          instr_mem [FBUF_DEPTH];
  logic            fault_mem [FBUF_DEPTH];

  // Pointers wrap on their own since the depth is a power of two
  logic [$clog2(FBUF_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(FBUF_DEPTH)-1:0] rd_ptr_q;
  logic [FBUF_CNT_W-1:0]         count_q;

  // Address of the next answer that belongs to the current stream
  logic [XLEN-1:0] exp_pc_q;

  logic ans_match;
  logic wr_en;
  logic rd_en;
  logic clear;

  assign ans_match = icache_ans_i.valid & (icache_ans_i.vaddr == exp_pc_q);
  assign clear     = flush_i | redirect_i;
  // Answers in the redirect cycle belong to the old stream
  assign wr_en     = ans_match & ~clear;
  assign rd_en     = fetch_src.valid & fetch_src.ready;

  // Credit and cache-side level
  assign free_slots_o = FBUF_CNT_W'(FBUF_DEPTH) - count_q;
  assign data_ready_o = (count_q != FBUF_CNT_W'(FBUF_DEPTH));

  // Head of the FIFO toward issue
  assign fetch_src.valid = (count_q != '0);
  assign fetch_src.pc    = pc_mem[rd_ptr_q];
  assign fetch_src.instr = instr_mem[rd_ptr_q];
  assign fetch_src.fault = fault_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      pc_mem[wr_ptr_q]        <= icache_ans_i.vaddr;
      instr_mem[wr_ptr_q].raw <= icache_ans_i.line;
      fault_mem[wr_ptr_q]     <= icache_ans_i.fault;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + FBUF_CNT_W'(wr_en) - FBUF_CNT_W'(rd_en);
    end
  end

  // Expected address follows the same target pc_gen takes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exp_pc_q <= BOOT_PC;
    end else if (redirect_i) begin
      exp_pc_q <= redirect_pc_i;
    end else if (ans_match) begin
      // Keeps tracking the stream even when a flush drops the entry
      exp_pc_q <= exp_pc_q + XLEN'(4);
    end
  end

  // Credit counting in pc_gen keeps answers off a full buffer
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_en |-> count_q < FBUF_CNT_W'(FBUF_DEPTH));

endmodule

// File: pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            except_i,
  input  logic [len5_pkg::XLEN-1:0]       except_pc_i,
  input  len5_pkg::resolution_t           res_i,
  input  logic                            pred_redirect_i,
  input  logic [len5_pkg::XLEN-1:0]       pred_target_i,
  input  logic                            ans_valid_i,
  input  logic [memory_pkg::FBUF_CNT_W-1:0] free_slots_i,
  input  logic                            addr_ready_i,
  output logic [len5_pkg::XLEN-1:0]       addr_o,
  output logic                            addr_valid_o,
  output logic                            redirect_o,
  output logic [len5_pkg::XLEN-1:0]       redirect_pc_o
);

  import len5_pkg::*;
  import memory_pkg::*;

  logic [XLEN-1:0]       pc_q;
  logic [FBUF_CNT_W-1:0] inflight_q;
  logic                  run_q;
  logic                  mispredict;
  logic                  req_acc;

  assign mispredict = res_i.valid & res_i.mispredict;

  // Redirect priority: exception, then mispredict, then predicted jump
  always_comb begin
    redirect_o    = 1'b1;
    redirect_pc_o = pc_q;
    if (except_i) begin
      redirect_pc_o = except_pc_i;
    end else if (mispredict) begin
      redirect_pc_o = res_i.target;
    end else if (pred_redirect_i) begin
      redirect_pc_o = pred_target_i;
    end else begin
      redirect_o = 1'b0;
    end
  end

  // Request only with credit left; credit is free slots not yet promised
  assign addr_o       = pc_q;
  assign addr_valid_o = run_q & ~redirect_o & (free_slots_i > inflight_q);
  assign req_acc      = addr_valid_o & addr_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q  <= BOOT_PC;
      run_q <= 1'b0;
    end else begin
      // Holds requests off during the first cycle out of reset
      run_q <= 1'b1;
      if (redirect_o) begin
        pc_q <= redirect_pc_o;
      end else if (req_acc) begin
        pc_q <= pc_q + XLEN'(4);
      end
    end
  end

  // Requests sent but not answered yet
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      inflight_q <= '0;
    end else begin
      case ({req_acc, ans_valid_i})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // Cache never owes more answers than the buffer can take
  a_inflight_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    inflight_q <= FBUF_CNT_W'(FBUF_DEPTH));

  // Word fetches only
  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    addr_valid_o |-> addr_o[1:0] == 2'b00);

endmodule

// File: fetch_if.sv
`timescale 1ns/1ps

interface fetch_if;

  import len5_pkg::*;

  // Handshake
  logic            valid;
  logic            ready;

  // Entry payload
  logic [XLEN-1:0] pc;
  instr_u          instr;
  logic            fault;

  // Buffer side
  modport src (
    output valid,
    output pc,
    output instr,
    output fault,
    input  ready
  );

  // Issue side
  modport dst (
    input  valid,
    input  pc,
    input  instr,
    input  fault,
    output ready
  );

endinterface

// File: memory_pkg.sv
package memory_pkg;

  // Answer of the instruction cache, one word per request
  typedef struct packed {
    logic                      valid;
    // Address the answer belongs to
    logic [len5_pkg::XLEN-1:0] vaddr;
    logic [len5_pkg::ILEN-1:0] line;
    // Access fault on this fetch
    logic                      fault;
  } icache_frontend_ans_t;

  // Fetch buffer entries
  localparam int unsigned FBUF_DEPTH = 4;

  // Wide enough to hold 0..FBUF_DEPTH
  localparam int unsigned FBUF_CNT_W = 3;

endpackage

// File: len5_pkg.sv
package len5_pkg;

  // Core-wide widths
  localparam int unsigned XLEN = 32;
  localparam int unsigned ILEN = 32;

  // Reset vector of the fetch unit
  localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_0100;

  // Opcodes seen by the predecoder
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // Static prediction attached to each issued instruction
  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } prediction_t;

  // Outcome of a branch coming back from the branch unit
  typedef struct packed {
    logic            valid;
    logic            mispredict;
    // Address fetch must restart from on a mispredict
    logic [XLEN-1:0] target;
  } resolution_t;

  // RISC-V mcause values raised by the front end
  typedef enum logic [3:0] {
    INSTR_MISALIGNED   = 4'd0,
    INSTR_ACCESS_FAULT = 4'd1
  } except_code_t;

  // One instruction word, read either raw or through the B/J fields
  typedef union packed {
    logic [ILEN-1:0] raw;
    struct packed {
      // Bit 31 is the immediate sign in both formats
      logic [6:0] imm_hi;
      // Low J immediate bits share the rs2 slot
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      // B-type keeps imm[4:1] and imm[11] where rd would be
      logic [4:0] rd_imm;
      logic [6:0] opcode;
    } bj;
  } instr_u;

endpackage
